// ==== verilog/bpPkg.sv ====
// Shared types and constants for the fetch-side branch predictor
// Covers opcodes, branch functions, PC words and 2-bit counters

package bpPkg;

    // One instruction address, byte addressed, word aligned
    typedef logic [31:0] pcT;

    // Raw 32-bit instruction word
    typedef logic [31:0] instrT;

    // Major opcodes that matter for prediction
    // Every other encoding is handled as a plain instruction
    typedef enum logic [6:0] {
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111
    } opcodeE;

    // funct3 values of the conditional branches that get resolved
    typedef enum logic [2:0] {
        FnBeq = 3'b000,
        FnBne = 3'b001
    } branchFuncE;

    // 2-bit saturating direction counter
    // The top bit gives the predicted direction
    typedef logic [1:0] ctrT;

    localparam ctrT CtrStrongNotTaken = 2'b00;
    localparam ctrT CtrWeakNotTaken   = 2'b01;
    localparam ctrT CtrStrongTaken    = 2'b11;

    // Default start address after reset
    localparam pcT ResetPcDefault = 32'h0000_0000;

    // Byte distance to the next sequential instruction
    localparam pcT PcStep = 32'd4;

endpackage

// ==== verilog/fetchPc.sv ====
// Fetch PC register
// Picks recovery, hold, predicted target or the next sequential word

module fetchPc #(
    parameter bpPkg::pcT ResetPc = bpPkg::ResetPcDefault
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  logic      mispredict_i,
    input  bpPkg::pcT recoverPc_i,
    input  logic      predTaken_i,
    input  bpPkg::pcT btbTarget_i,
    output bpPkg::pcT pcF_o,
    output bpPkg::pcT pcPlus4F_o
);

    import bpPkg::*;

    pcT nextPc;

    assign pcPlus4F_o = pcF_o + PcStep;

    // Recovery beats a stall, a stall beats prediction
    always_comb begin
        if (mispredict_i) begin
            nextPc = recoverPc_i;
        end else if (stall_i) begin
            nextPc = pcF_o;
        end else if (predTaken_i) begin
            nextPc = btbTarget_i;
        end else begin
            nextPc = pcPlus4F_o;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= ResetPc;
        end else begin
            pcF_o <= nextPc;
        end
    end

endmodule

// ==== verilog/branchTargetBuffer.sv ====
// Direct-mapped branch target buffer
// Tagged by the PC bits above the index, read in fetch, written from execute

module branchTargetBuffer #(
    parameter int BtbEntries = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  bpPkg::pcT pcF_i,
    output logic      hit_o,
    output bpPkg::pcT target_o,
    input  logic      we_i,
    input  bpPkg::pcT writePc_i,
    input  bpPkg::pcT writeTarget_i
);

    localparam int IdxBits = $clog2(BtbEntries);
    localparam int TagBits = 30 - IdxBits;

    logic [BtbEntries-1:0] valid;
    logic [TagBits-1:0]    tagMem [BtbEntries];
    logic [31:0]           targetMem [BtbEntries];

    logic [IdxBits-1:0] rdIdx;
    logic [TagBits-1:0] rdTag;
    logic [IdxBits-1:0] wrIdx;
    logic [TagBits-1:0] wrTag;

    // Word offset is dropped, index sits right above it
    assign rdIdx = pcF_i[IdxBits+1:2];
    assign rdTag = pcF_i[31:IdxBits+2];
    assign wrIdx = writePc_i[IdxBits+1:2];
    assign wrTag = writePc_i[31:IdxBits+2];

    assign hit_o    = valid[rdIdx] && (tagMem[rdIdx] == rdTag);
    assign target_o = targetMem[rdIdx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (we_i) begin
            valid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tagMem[wrIdx]    <= wrTag;
            targetMem[wrIdx] <= writeTarget_i;
        end
    end

endmodule

// ==== verilog/directionPredictor.sv ====
// Gshare direction predictor
// Global history XOR PC selects a 2-bit saturating counter

module directionPredictor #(
    parameter int GhrBits = 5
) (
    input  logic               clk,
    input  logic               reset,
    input  bpPkg::pcT          pcF_i,
    input  bpPkg::opcodeE      opF_i,
    input  logic               stall_i,
    input  logic               predTaken_i,
    output logic               counterTaken_o,
    output logic [GhrBits-1:0] index_o,
    input  logic               update_i,
    input  logic               taken_i,
    input  logic [GhrBits-1:0] updateIndex_i,
    input  logic               historyClear_i
);

    import bpPkg::*;

    localparam int PhtEntries = 1 << GhrBits;

    logic [GhrBits-1:0] ghr;
    ctrT                pht [PhtEntries];
    logic               shiftHistory;

    assign index_o        = ghr ^ pcF_i[GhrBits+1:2];
    assign counterTaken_o = pht[index_o][1];

    // Speculative history, one bit per branch leaving fetch
    assign shiftHistory = !stall_i && (opF_i == OpBranch);

    always_ff @(posedge clk) begin
        if (reset || historyClear_i) begin
            ghr <= '0;
        end else if (shiftHistory) begin
            ghr <= {ghr[GhrBits-2:0], predTaken_i};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                pht[i] <= CtrWeakNotTaken;
            end
        end else if (update_i) begin
            // Saturate at both ends
            if (taken_i && (pht[updateIndex_i] != CtrStrongTaken)) begin
                pht[updateIndex_i] <= pht[updateIndex_i] + 2'd1;
            end else if (!taken_i && (pht[updateIndex_i] != CtrStrongNotTaken)) begin
                pht[updateIndex_i] <= pht[updateIndex_i] - 2'd1;
            end
        end
    end

endmodule

// ==== verilog/stagePipeline.sv ====
// Decode and execute pipeline registers for the fetched instruction
// Decode extracts the B or J immediate, execute carries the prediction state

module stagePipeline #(
    parameter int GhrBits = 5
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    input  logic                 flush_i,
    input  bpPkg::instrT         instrF_i,
    input  bpPkg::pcT            pcF_i,
    input  bpPkg::pcT            pcPlus4F_i,
    input  logic                 predTakenF_i,
    input  logic [GhrBits-1:0]   indexF_i,
    output bpPkg::opcodeE        opE_o,
    output bpPkg::branchFuncE    funct3E_o,
    output bpPkg::pcT            immE_o,
    output bpPkg::pcT            pcE_o,
    output bpPkg::pcT            pcPlus4E_o,
    output logic                 predTakenE_o,
    output logic [GhrBits-1:0]   indexE_o
);

    import bpPkg::*;

    // Decode registers
    instrT              instrD;
    pcT                 pcD;
    pcT                 pcPlus4D;
    logic               predTakenD;
    logic [GhrBits-1:0] indexD;

    opcodeE     opD;
    branchFuncE funct3D;
    pcT         immD;

    assign opD     = opcodeE'(instrD[6:0]);
    assign funct3D = branchFuncE'(instrD[14:12]);

    // Only jal needs the J format here, everything else uses B
    always_comb begin
        case (opD)
            OpJal: immD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                           instrD[30:21], 1'b0};
            default: immD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                             instrD[11:8], 1'b0};
        endcase
    end

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            instrD     <= '0;
            pcD        <= '0;
            pcPlus4D   <= '0;
            predTakenD <= 1'b0;
            indexD     <= '0;
        end else if (!stall_i) begin
            instrD     <= instrF_i;
            pcD        <= pcF_i;
            pcPlus4D   <= pcPlus4F_i;
            predTakenD <= predTakenF_i;
            indexD     <= indexF_i;
        end
    end

    // A stalled decode sends a bubble into execute
    always_ff @(posedge clk) begin
        if (reset || flush_i || stall_i) begin
            opE_o        <= opcodeE'(7'd0);
            funct3E_o    <= branchFuncE'(3'd0);
            immE_o       <= '0;
            pcE_o        <= '0;
            pcPlus4E_o   <= '0;
            predTakenE_o <= 1'b0;
            indexE_o     <= '0;
        end else begin
            opE_o        <= opD;
            funct3E_o    <= funct3D;
            immE_o       <= immD;
            pcE_o        <= pcD;
            pcPlus4E_o   <= pcPlus4D;
            predTakenE_o <= predTakenD;
            indexE_o     <= indexD;
        end
    end

endmodule

// ==== verilog/branchResolve.sv ====
// Execute-stage branch resolution
// Flags mispredictions and drives the BTB and counter table updates

module branchResolve (
    input  bpPkg::opcodeE     opE_i,
    input  bpPkg::branchFuncE funct3E_i,
    input  logic              zeroE_i,
    input  bpPkg::pcT         immE_i,
    input  bpPkg::pcT         pcE_i,
    input  bpPkg::pcT         pcPlus4E_i,
    input  logic              predTakenE_i,
    output logic              mispredict_o,
    output bpPkg::pcT         recoverPc_o,
    output logic              btbWe_o,
    output bpPkg::pcT         btbTarget_o,
    output logic              phtUpdate_o,
    output logic              phtTaken_o
);

    import bpPkg::*;

    logic isBranch;
    logic isJal;
    logic branchTaken;
    pcT   targetE;

    assign isBranch = (opE_i == OpBranch);
    assign isJal    = (opE_i == OpJal);

    // beq taken on equal, bne on not equal
    assign branchTaken = isBranch &&
                         (((funct3E_i == FnBeq) && zeroE_i) ||
                          ((funct3E_i == FnBne) && !zeroE_i));

    assign targetE = pcE_i + immE_i;

    // jal is always taken, so only a missed prediction counts
    assign mispredict_o = (isBranch && (predTakenE_i != branchTaken)) ||
                          (isJal && !predTakenE_i);

    // Wrongly taken resumes after the branch, wrongly not taken jumps to the target
    assign recoverPc_o = predTakenE_i ? pcPlus4E_i : targetE;

    assign btbWe_o     = branchTaken || isJal;
    assign btbTarget_o = targetE;

    // Counters learn from every resolved branch
    assign phtUpdate_o = isBranch;
    assign phtTaken_o  = branchTaken;

endmodule

// ==== verilog/fetchPredictTop.sv ====
// Fetch side of one issue slot with a BTB and a gshare direction predictor
// Branches and jal resolve in execute and redirect fetch on a misprediction

module fetchPredictTop #(
    parameter int        BtbEntries = 32,
    parameter int        GhrBits    = 5,
    parameter bpPkg::pcT ResetPc    = bpPkg::ResetPcDefault
) (
    input  logic         clk,
    input  logic         reset,
    input  bpPkg::instrT InstrF_i,
    input  logic         Stall_i,
    input  logic         ZeroE_i,
    output bpPkg::pcT    PCF_o,
    output logic         Mispredict_o
);

    import bpPkg::*;

    // Fetch stage
    pcT               pcF;
    pcT               pcPlus4F;
    opcodeE           opF;
    logic             btbHit;
    pcT               btbTargetF;
    logic             counterTaken;
    logic [GhrBits-1:0] indexF;
    logic             predTakenF;

    // Execute stage
    opcodeE           opE;
    branchFuncE       funct3E;
    pcT               immE;
    pcT               pcE;
    pcT               pcPlus4E;
    logic             predTakenE;
    logic [GhrBits-1:0] indexE;

    // Resolution results
    logic             mispredict;
    pcT               recoverPc;
    logic             btbWe;
    pcT               btbWriteTarget;
    logic             phtUpdate;
    logic             phtTaken;

    assign opF = opcodeE'(InstrF_i[6:0]);

    // Taken only when the BTB knows a target for this PC
    assign predTakenF = btbHit && ((opF == OpJal) || ((opF == OpBranch) && counterTaken));

    fetchPc #(
        .ResetPc(ResetPc)
    ) fetchPc0 (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (Stall_i),
        .mispredict_i(mispredict),
        .recoverPc_i (recoverPc),
        .predTaken_i (predTakenF),
        .btbTarget_i (btbTargetF),
        .pcF_o       (pcF),
        .pcPlus4F_o  (pcPlus4F)
    );

    branchTargetBuffer #(
        .BtbEntries(BtbEntries)
    ) btb0 (
        .clk          (clk),
        .reset        (reset),
        .pcF_i        (pcF),
        .hit_o        (btbHit),
        .target_o     (btbTargetF),
        .we_i         (btbWe),
        .writePc_i    (pcE),
        .writeTarget_i(btbWriteTarget)
    );

    directionPredictor #(
        .GhrBits(GhrBits)
    ) dirPred0 (
        .clk           (clk),
        .reset         (reset),
        .pcF_i         (pcF),
        .opF_i         (opF),
        .stall_i       (Stall_i),
        .predTaken_i   (predTakenF),
        .counterTaken_o(counterTaken),
        .index_o       (indexF),
        .update_i      (phtUpdate),
        .taken_i       (phtTaken),
        .updateIndex_i (indexE),
        .historyClear_i(mispredict)
    );

    stagePipeline #(
        .GhrBits(GhrBits)
    ) pipe0 (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (Stall_i),
        .flush_i     (mispredict),
        .instrF_i    (InstrF_i),
        .pcF_i       (pcF),
        .pcPlus4F_i  (pcPlus4F),
        .predTakenF_i(predTakenF),
        .indexF_i    (indexF),
        .opE_o       (opE),
        .funct3E_o   (funct3E),
        .immE_o      (immE),
        .pcE_o       (pcE),
        .pcPlus4E_o  (pcPlus4E),
        .predTakenE_o(predTakenE),
        .indexE_o    (indexE)
    );

    branchResolve resolve0 (
        .opE_i       (opE),
        .funct3E_i   (funct3E),
        .zeroE_i     (ZeroE_i),
        .immE_i      (immE),
        .pcE_i       (pcE),
        .pcPlus4E_i  (pcPlus4E),
        .predTakenE_i(predTakenE),
        .mispredict_o(mispredict),
        .recoverPc_o (recoverPc),
        .btbWe_o     (btbWe),
        .btbTarget_o (btbWriteTarget),
        .phtUpdate_o (phtUpdate),
        .phtTaken_o  (phtTaken)
    );

    assign PCF_o        = pcF;
    assign Mispredict_o = mispredict;

endmodule

// ==== verif/fetchPredict_sva.sv ====
// Concurrent checks on the fetch predictor top level
// Covers PC alignment, single-cycle mispredict pulses and stall hold

module fetchPredictSva (
    input logic      clk,
    input logic      reset,
    input logic      stall_i,
    input logic      mispredict_i,
    input bpPkg::pcT pcF_i
);

    int failCount = 0;

    // Fetch addresses stay on word boundaries
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        pcF_i[1:0] == 2'b00)
    else begin
        failCount++;
        $error("fetch PC %h is not word aligned", pcF_i);
    end

    // The flushed execute stage cannot mispredict again
    mispredictPulse: assert property (@(posedge clk) disable iff (reset)
        mispredict_i |=> !mispredict_i)
    else begin
        failCount++;
        $error("mispredict high two cycles in a row");
    end

    stallHold: assert property (@(posedge clk) disable iff (reset)
        (stall_i && !mispredict_i) |=> (pcF_i == $past(pcF_i)))
    else begin
        failCount++;
        $error("fetch PC moved during a stall");
    end

endmodule

bind fetchPredictTop fetchPredictSva sva0 (
    .clk         (clk),
    .reset       (reset),
    .stall_i     (Stall_i),
    .mispredict_i(Mispredict_o),
    .pcF_i       (PCF_o)
);

// ==== verif/fetchPredictTb.sv ====
// Testbench for the fetch-side branch predictor
// Runs small programs from a table and checks mispredict counts and fetch PCs

module fetchPredictTb;

    import bpPkg::*;

    localparam int NumRows      = 5;
    localparam int MaxWords     = 2;
    localparam pcT StartPc      = ResetPcDefault;
    localparam int ResetCycles  = 2;

    logic  clk;
    logic  reset;
    instrT instrF;
    logic  stall;
    logic  zeroE;
    pcT    pcF;
    logic  mispredict;

    // Scenario table, one row per program
    pcT    progPc     [NumRows][MaxWords];
    instrT progWord   [NumRows][MaxWords];
    int    progCount  [NumRows];
    pcT    branchPc   [NumRows];
    int    takenLimit [NumRows];
    int    numCycles  [NumRows];
    logic  useStall   [NumRows];
    int    expMisp    [NumRows];
    pcT    expPc      [NumRows];

    // Shadow of the PCs held in decode and execute
    logic decValid;
    pcT   decPc;
    logic exValid;
    pcT   exPc;

    integer seed;
    int     errors;
    int     execCount;
    int     mispCount;
    int     stallCount;

    fetchPredictTop #(
        .BtbEntries(32),
        .GhrBits   (5),
        .ResetPc   (StartPc)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .InstrF_i    (instrF),
        .Stall_i     (stall),
        .ZeroE_i     (zeroE),
        .PCF_o       (pcF),
        .Mispredict_o(mispredict)
    );

    always #2 clk = ~clk;

    function automatic instrT branchWord(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic instrT jalWord(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    endfunction

    // Unlisted addresses return an addi whose upper bits carry the address
    function automatic instrT memWord(input int row, input pcT pc);
        instrT word;
        word = {pc[31:7] ^ {20'd0, pc[6:2]}, 7'b0010011};
        for (int k = 0; k < progCount[row]; k++) begin
            if (progPc[row][k] == pc) begin
                word = progWord[row][k];
            end
        end
        return word;
    endfunction

    task automatic setRow(input int row, input int cyc, input logic stl, input int misp,
                          input pcT finalPc, input pcT brPc, input int limit);
        numCycles[row]  = cyc;
        useStall[row]   = stl;
        expMisp[row]    = misp;
        expPc[row]      = finalPc;
        branchPc[row]   = brPc;
        takenLimit[row] = limit;
        progCount[row]  = 0;
    endtask

    task automatic addWord(input int row, input pcT pc, input instrT word);
        progPc[row][progCount[row]]   = pc;
        progWord[row][progCount[row]] = word;
        progCount[row]++;
    endtask

    task automatic loadTable();
        // Straight line, 20 fetches if never stalled
        setRow(0, 20, 1'b1, 0, 32'h50, 32'hFFFF_FFF0, 0);
        // beq at 0x8 always taken to 0x28, words at 0xC and 0x10 get squashed
        setRow(1, 8, 1'b0, 1, 32'h34, 32'h8, 1000);
        addWord(1, 32'h8, branchWord(3'b000, 13'h0020));
        // jal 0x8 to 0x18 and jal 0x18 back to 0x0, cold misses then BTB hits
        setRow(2, 14, 1'b0, 2, 32'h8, 32'hFFFF_FFF0, 0);
        addWord(2, 32'h08, jalWord(21'h00010));
        addWord(2, 32'h18, jalWord(21'h1FFFE8));
        // bne at 0x4 never taken
        setRow(3, 10, 1'b0, 0, 32'h28, 32'h4, 0);
        addWord(3, 32'h4, branchWord(3'b001, 13'h0040));
        // Loop bne at 0x10 back to 0x0, taken 3 times then exits to 0x14
        // Misses on the cold pass, on pass 3 (history 00001 picks a fresh counter) and on exit
        setRow(4, 30, 1'b0, 3, 32'h24, 32'h10, 3);
        addWord(4, 32'h10, branchWord(3'b001, 13'h1FF0));
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp, input int row);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h expected %h in row %0d", name, got, exp, row);
        end
    endtask

    task automatic resetDut(input int row);
        reset  = 1'b1;
        stall  = 1'b0;
        zeroE  = 1'b0;
        instrF = memWord(row, StartPc);
        repeat (ResetCycles) begin
            @(negedge clk);
        end
        reset = 1'b0;
        checkValue("PCF_o", pcF, StartPc, row);
        checkValue("Mispredict_o", mispredict, 32'd0, row);
        decValid   = 1'b0;
        exValid    = 1'b0;
        decPc      = '0;
        exPc       = '0;
        execCount  = 0;
        mispCount  = 0;
        stallCount = 0;
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic runCycle(input int row);
        logic  taken;
        logic  isBeq;
        logic  stallNow;
        logic  mispNow;
        pcT    fetchedPc;
        instrT brWord;
        brWord   = memWord(row, branchPc[row]);
        isBeq    = (brWord[14:12] == 3'b000);
        stallNow = 1'b0;
        zeroE    = 1'b0;
        if (exValid && (exPc == branchPc[row])) begin
            taken = (execCount < takenLimit[row]);
            execCount++;
            zeroE = isBeq ? taken : !taken;
        end
        if (useStall[row]) begin
            stallNow = (($random(seed) & 3) == 0);
        end
        stall  = stallNow;
        instrF = memWord(row, pcF);
        #1;
        fetchedPc = pcF;
        mispNow   = mispredict;
        if (mispNow) begin
            mispCount++;
        end
        if (stallNow) begin
            stallCount++;
        end
        @(negedge clk);
        if (stallNow && !mispNow) begin
            checkValue("PCF_o", pcF, fetchedPc, row);
        end
        if (useStall[row] && !stallNow && !mispNow) begin
            checkValue("PCF_o", pcF, fetchedPc + 32'd4, row);
        end
        // Follow the flush, bubble and shift rules of the pipeline
        if (mispNow) begin
            decValid = 1'b0;
            exValid  = 1'b0;
        end else if (stallNow) begin
            exValid = 1'b0;
        end else begin
            exValid  = decValid;
            exPc     = decPc;
            decValid = 1'b1;
            decPc    = fetchedPc;
        end
    endtask

    task automatic runRow(input int row);
        resetDut(row);
        for (int c = 0; c < numCycles[row]; c++) begin
            runCycle(row);
        end
        checkValue("Mispredict_o pulses", mispCount, expMisp[row], row);
        // Stalled cycles do not advance straight-line fetch
        checkValue("PCF_o", pcF, expPc[row] - 32'(4 * stallCount), row);
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        stall  = 1'b0;
        zeroE  = 1'b0;
        instrF = '0;
        seed   = 32'h414fc9b9;
        errors = 0;
        loadTable();
        @(negedge clk);
        for (int row = 0; row < NumRows; row++) begin
            runRow(row);
        end
        errors = errors + dut0.sva0.failCount;
        $display("rows %0d errors %0d", NumRows, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== fetchPredictTop.f ====
verilog/bpPkg.sv
verilog/fetchPc.sv
verilog/branchTargetBuffer.sv
verilog/directionPredictor.sv
verilog/stagePipeline.sv
verilog/branchResolve.sv
verilog/fetchPredictTop.sv
verif/fetchPredict_sva.sv
verif/fetchPredictTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = fetchPredictTb
FILELIST  = fetchPredictTop.f
OBJDIR    = obj_dir
PASSMSG   = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASSMSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
